// File: build.f
+incdir+hw
hw/spiRegPkg.sv
hw/spiLinkPkg.sv
hw/spiRegs.sv
hw/spiFifo.sv
hw/spiEngine.sv
hw/spiApb.sv
test/spiApbSva.sv
test/spiApbTb.sv

// File: Bender.yml
package:
  name: spi_apb

export_include_dirs:
  - hw

sources:
  - hw/spiRegPkg.sv
  - hw/spiLinkPkg.sv
  - hw/spiRegs.sv
  - hw/spiFifo.sv
  - hw/spiEngine.sv
  - hw/spiApb.sv
  - target: test
    files:
      - test/spiApbSva.sv
      - test/spiApbTb.sv

// File: test/spiApbTb.sv
////////////////////
// APB SPI master testbench
// APB driver, mode 0 slave model on the pins, reference checks
// for frames, chip selects, clock timing and interrupts
////////////////////
`timescale 1ns/1ns
`include "spi_config.svh"

module spiApbTb;
    import spiRegPkg::*;
    import spiLinkPkg::*;

    localparam int RxPolls  = 400;                   // RXDATA reads before giving up
    localparam int IdleWait = 2000;                  // PCLK cycles
    localparam int PoolSize = 64;
    localparam int Depth    = 1 << `SPI_FIFO_ABITS;

    logic        PCLK;
    logic        PRESETn;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [7:0]  PADDR;
    spiDataWordT PWDATA;
    spiDataWordT PRDATA;
    logic        PREADY;
    logic        SPIOut;
    logic        SPIIn;
    logic [3:0]  SPICS;
    logic        SPICLK;
    logic        SPIIntr;

    // Programmed state, as the checkers expect it
    int         divCur;
    logic [1:0] csIdCur;
    logic [3:0] csDefCur;
    int         txMarkCur;
    int         rxMarkCur;
    spiIrqT     ieCur;

    spiByteT sentQ[$];                 // Bytes the slave should capture
    spiByteT respQ[$];                 // Bytes the slave sent back
    spiByteT respPool [PoolSize];
    int      framesSeen  = 0;
    int      frameStarts = 0;
    spiByteT slvIn;                    // Shifted in from SPIOut
    spiByteT slvOut;                   // Response going out on SPIIn
    int      slvBits;
    int      runLen;                   // PCLK cycles at the current SPICLK level
    int      clkEdges;
    logic    clkPrev;

    int byteErrs    = 0;
    int wordErrs    = 0;
    int csErrs      = 0;
    int countErrs   = 0;
    int bitErrs     = 0;
    int timeoutErrs = 0;

    spiApb i_spiApb (.*);

    initial begin
        PCLK = 1'b0;
        forever #20 PCLK = ~PCLK;
    end

    ////////////////////
    // Reference and compare

    // Selected line leaves its idle level during a frame
    function automatic logic [3:0] activeCs(input logic [1:0] id, input logic [3:0] def);
        logic [3:0] cs;
        cs     = def;
        cs[id] = ~def[id];
        return cs;
    endfunction

    function automatic spiIrqT ipRule(input int txLvl, input int rxLvl);
        spiIrqT ip;
        ip.txLow  = (txLvl < txMarkCur);
        ip.rxHigh = (rxLvl > rxMarkCur);
        return ip;
    endfunction

    task automatic checkByte(input string name, input spiByteT got, input spiByteT want);
        if (got !== want) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
            byteErrs++;
        end
    endtask

    task automatic checkWord(input string name, input spiDataWordT got,
                             input spiDataWordT want);
        if (got.raw !== want.raw) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got.raw, want.raw);
            wordErrs++;
        end
    endtask

    task automatic checkCs(input string name, input logic [3:0] got, input logic [3:0] want);
        if (got !== want) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, want);
            csErrs++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int want);
        if (got != want) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, want);
            countErrs++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, want);
            bitErrs++;
        end
    endtask

    task automatic finishRun();
        int total;
        int assertErrs;
        assertErrs = i_spiApb.i_spiApbSva.assertFails;   // Bound assertion failures
        total = byteErrs + wordErrs + csErrs + countErrs + bitErrs + timeoutErrs + assertErrs;
        $display("errors: byte %0d, word %0d, cs %0d, count %0d, bit %0d, timeout %0d, %s %0d",
                 byteErrs, wordErrs, csErrs, countErrs, bitErrs, timeoutErrs, "assertion",
                 assertErrs);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic abortRun(input string what);
        $display("timeout at %0t: %s", $time, what);
        timeoutErrs++;
        finishRun();
    endtask

    ////////////////////
    // SPI slave model

    // Frame start, first response bit is ready before the first rise
    always @(SPICS) begin
        if (PRESETn === 1'b1 && SPICS !== csDefCur) begin
            slvOut = respPool[frameStarts % PoolSize];
            respQ.push_back(slvOut);
            frameStarts++;
            slvBits = 0;
            #2 SPIIn = slvOut[`SPI_FRAME_BITS-1];
        end
    end

    always @(negedge SPICLK) begin
        if (PRESETn === 1'b1) begin
            slvOut = slvOut << 1;
            #2 SPIIn = slvOut[`SPI_FRAME_BITS-1];    // Next bit after the fall
        end
    end

    // Capture on rise, compare each finished byte
    always @(posedge SPICLK) begin
        if (PRESETn === 1'b1) begin
            checkCs("SPICS", SPICS, activeCs(csIdCur, csDefCur));
            slvIn = {slvIn[`SPI_FRAME_BITS-2:0], SPIOut};
            slvBits++;
            if (slvBits == `SPI_FRAME_BITS) begin
                framesSeen++;
                if (sentQ.size() == 0) begin
                    $display("slave captured a frame at %0t that was never written", $time);
                    byteErrs++;
                end else begin
                    checkByte("SPIOut frame", slvIn, sentQ.pop_front());
                end
            end
        end
    end

    // SPICLK half periods in PCLK cycles, first low of a frame skipped
    always @(negedge PCLK) begin
        if (PRESETn !== 1'b1) begin
            runLen   = 0;
            clkEdges = 0;
            clkPrev  = 1'b0;
        end else begin
            if (SPICS === csDefCur) clkEdges = 0;
            if (SPICLK !== clkPrev) begin
                if (clkPrev) checkCount("SPICLK high time", runLen, divCur + 1);
                else if (clkEdges != 0) checkCount("SPICLK low time", runLen, divCur + 1);
                clkEdges++;
                runLen = 1;
            end else begin
                runLen++;
            end
            clkPrev = SPICLK;
        end
    end

    ////////////////////
    // APB driver and waits

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        @(posedge PCLK);
        #2;
        PSEL       = 1'b1;
        PWRITE     = 1'b1;
        PADDR      = addr;
        PWDATA.raw = data;
        @(posedge PCLK);
        #2;
        PENABLE = 1'b1;                              // Access phase, no wait states
        @(posedge PCLK);
        #2;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output spiDataWordT data);
        @(posedge PCLK);
        #2;
        PSEL   = 1'b1;
        PWRITE = 1'b0;
        PADDR  = addr;
        @(posedge PCLK);
        #2;
        PENABLE = 1'b1;
        @(negedge PCLK);
        data = PRDATA;                               // Mid access phase
        @(posedge PCLK);
        #2;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge PCLK);
        end
        #2;
    endtask

    task automatic waitCsIdle();
        int n;
        n = 0;
        while (SPICS !== csDefCur && n < IdleWait) begin
            @(negedge PCLK);
            n++;
        end
        if (SPICS !== csDefCur) abortRun("chip selects never returned to idle");
    endtask

    task automatic waitFrames(input int target);
        int n;
        n = 0;
        while (framesSeen < target && n < IdleWait) begin
            @(negedge PCLK);
            n++;
        end
        if (framesSeen < target) abortRun("slave did not see all frames");
    endtask

    // Past the release half period, engine back in idle
    task automatic settle();
        waitCsIdle();
        idleCycles(divCur + 3);
        checkCs("SPICS idle", SPICS, csDefCur);
    endtask

    task automatic setConfig(input int div, input logic [1:0] id, input logic [3:0] def);
        apbWrite(`SPI_OFS_SCKDIV, 32'(div));
        apbWrite(`SPI_OFS_CSID, 32'(id));
        apbWrite(`SPI_OFS_CSDEF, 32'(def));
        divCur   = div;
        csIdCur  = id;
        csDefCur = def;
        idleCycles(2);                               // Snapshot takes them while idle
        checkCs("SPICS idle", SPICS, def);
    endtask

    // Poll RXDATA until a byte shows up, compare with the slave's response
    task automatic drainRx(input int n);
        spiDataWordT w;
        int          tries;
        for (int i = 0; i < n; i++) begin
            tries = 0;
            do begin
                apbRead(`SPI_OFS_RXDATA, w);
                tries++;
            end while (w.data.flag && tries < RxPolls);
            if (w.data.flag) begin
                abortRun("no received byte showed up in RXDATA");
            end else if (respQ.size() == 0) begin
                $display("RXDATA returned a byte at %0t with no slave response", $time);
                byteErrs++;
            end else begin
                checkByte("RXDATA", w.data.value, respQ.pop_front());
            end
        end
    endtask

    task automatic checkIrq(input int txLvl, input int rxLvl);
        spiDataWordT got;
        spiDataWordT want;
        spiIrqT      ip;
        ip       = ipRule(txLvl, rxLvl);
        want.raw = {30'b0, ip};
        apbRead(`SPI_OFS_IP, got);
        checkWord("IP", got, want);
        checkBit("SPIIntr", SPIIntr, |(ip & ieCur));
    endtask

    ////////////////////
    // Stimulus

    initial begin
        spiDataWordT w;
        spiDataWordT want;
        spiByteT     b;
        spiByteT     burst [Depth + 4];
        int          n;
        int          startsBefore;
        int          framesBefore;
        int          accepted;

        void'($urandom(54413));
        PRESETn    = 1'b0;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        PWRITE     = 1'b0;
        PADDR      = '0;
        PWDATA.raw = '0;
        SPIIn      = 1'b0;
        divCur     = 3;
        csIdCur    = 2'd0;
        csDefCur   = 4'b1111;
        txMarkCur  = 0;
        rxMarkCur  = 0;
        ieCur      = '0;
        for (int i = 0; i < PoolSize; i++) begin
            respPool[i] = spiByteT'($urandom);
        end
        repeat (10) @(posedge PCLK);
        #2;
        PRESETn = 1'b1;

        // Reset values
        want.raw = 32'd3;
        apbRead(`SPI_OFS_SCKDIV, w);
        checkWord("SCKDIV", w, want);
        want.raw = 32'hF;
        apbRead(`SPI_OFS_CSDEF, w);
        checkWord("CSDEF", w, want);
        want.raw = '0;
        apbRead(`SPI_OFS_IE, w);
        checkWord("IE", w, want);
        want.data.flag = 1'b1;                       // Empty flag only
        apbRead(`SPI_OFS_RXDATA, w);
        checkWord("RXDATA", w, want);
        checkCs("SPICS", SPICS, 4'b1111);
        checkBit("SPICLK", SPICLK, 1'b0);
        checkBit("SPIOut", SPIOut, 1'b0);
        checkBit("SPIIntr", SPIIntr, 1'b0);

        // Random bytes, dividers and chip selects
        for (int round = 0; round < 4; round++) begin
            setConfig($urandom_range(6, 0), 2'($urandom), 4'($urandom));
            n = $urandom_range(Depth, 3);
            for (int i = 0; i < n; i++) begin
                b = spiByteT'($urandom);
                sentQ.push_back(b);
                apbWrite(`SPI_OFS_TXDATA, 32'(b));
            end
            drainRx(n);
            settle();
        end

        // Overfill the transmit FIFO under a slow clock
        setConfig(20, 2'd1, 4'b1111);
        startsBefore = frameStarts;
        framesBefore = framesSeen;
        for (int i = 0; i < Depth + 4; i++) begin
            burst[i] = spiByteT'($urandom);
            apbWrite(`SPI_OFS_TXDATA, 32'(burst[i]));
        end
        accepted = Depth + frameStarts - startsBefore;   // Depth plus bytes already popped
        want.raw       = '0;
        want.data.flag = 1'b1;
        apbRead(`SPI_OFS_TXDATA, w);
        checkWord("TXDATA", w, want);
        for (int i = 0; i < accepted; i++) begin
            sentQ.push_back(burst[i]);
        end
        drainRx(accepted);
        settle();
        checkCount("frames seen", framesSeen - framesBefore, accepted);

        // Watermark interrupts
        setConfig(2, 2'd2, 4'b1111);
        txMarkCur = 2;
        rxMarkCur = 1;
        ieCur     = 2'b11;
        apbWrite(`SPI_OFS_TXMARK, 32'd2);
        apbWrite(`SPI_OFS_RXMARK, 32'd1);
        apbWrite(`SPI_OFS_IE, 32'd3);
        idleCycles(2);
        checkIrq(0, 0);
        framesBefore = framesSeen;
        for (int i = 0; i < 3; i++) begin
            b = spiByteT'($urandom);
            sentQ.push_back(b);
            apbWrite(`SPI_OFS_TXDATA, 32'(b));
        end
        waitFrames(framesBefore + 3);
        settle();
        checkIrq(0, 3);                              // Three bytes left in receive FIFO
        ieCur = 2'b01;
        apbWrite(`SPI_OFS_IE, 32'd1);
        idleCycles(1);
        checkIrq(0, 3);
        ieCur = '0;
        apbWrite(`SPI_OFS_IE, 32'd0);
        idleCycles(1);
        checkBit("SPIIntr", SPIIntr, 1'b0);
        drainRx(3);
        idleCycles(2);
        checkIrq(0, 0);
        txMarkCur = 0;
        apbWrite(`SPI_OFS_TXMARK, 32'd0);
        idleCycles(2);
        checkIrq(0, 0);

        checkCount("bytes never captured", sentQ.size(), 0);
        checkCount("responses never read", respQ.size(), 0);
        finishRun();
    end

endmodule

// File: test/spiApbSva.sv
////////////////////
// SPI master assertions
// APB ready, serial clock idle and one chip select change at a time
////////////////////
`timescale 1ns/1ns

module spiApbSva (
    input logic       PCLK,
    input logic       PRESETn,
    input logic       PREADY,
    input logic       SPICLK,
    input logic [3:0] SPICS,
    input logic [3:0] csDef      // Idle levels used by the running frame
);

    int assertFails = 0;         // Summed into the closing error count

    // No wait states on APB
    readyHigh: assert property (@(posedge PCLK) disable iff (!PRESETn) PREADY)
        else begin
            assertFails++;
            $error("PREADY dropped low");
        end

    // Serial clock only runs while a chip select is active
    clkIdle: assert property (@(posedge PCLK) disable iff (!PRESETn)
        (SPICS == csDef) |-> !SPICLK)
        else begin
            assertFails++;
            $error("SPICLK high with all chip selects idle");
        end

    // Only the selected line leaves or returns to idle while the idle levels hold
    oneCs: assert property (@(posedge PCLK) disable iff (!PRESETn)
        (csDef == $past(csDef)) |-> ($countones(SPICS ^ $past(SPICS)) <= 1))
        else begin
            assertFails++;
            $error("more than one chip select changed at once");
        end

endmodule

bind spiApb spiApbSva i_spiApbSva (
    .PCLK, .PRESETn, .PREADY, .SPICLK, .SPICS, .csDef(i_spiEngine.snap.csDef)
);

// File: hw/spiApb.sv
////////////////////
// APB SPI master
// Register block, transmit and receive FIFOs, transfer engine
////////////////////
`timescale 1ns/1ns

module spiApb (
    input  logic                   PCLK,
    input  logic                   PRESETn,
    input  logic                   PSEL,
    input  logic                   PENABLE,
    input  logic                   PWRITE,
    input  logic [7:0]             PADDR,
    input  spiRegPkg::spiDataWordT PWDATA,
    output spiRegPkg::spiDataWordT PRDATA,
    output logic                   PREADY,
    output logic                   SPIOut,
    input  logic                   SPIIn,
    output logic [3:0]             SPICS,
    output logic                   SPICLK,
    output logic                   SPIIntr
);
    import spiRegPkg::*;
    import spiLinkPkg::*;

    spiCtrlT     ctrl;        // Live control registers
    spiFifoStatT txStat;
    spiFifoStatT rxStat;
    logic        txPush;
    logic        txPop;
    logic        rxPush;
    logic        rxPop;
    spiByteT     txWrByte;    // Bus to transmit FIFO
    spiByteT     txHead;      // Transmit FIFO to engine
    spiByteT     rxWrByte;    // Engine to receive FIFO
    spiByteT     rxHead;      // Receive FIFO to bus

    spiRegs i_spiRegs (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PREADY,
        .ctrl, .txPush, .txByte(txWrByte), .txStat, .rxStat, .rxPop, .rxByte(rxHead),
        .SPIIntr
    );

    spiFifo txFifo (
        .PCLK, .PRESETn, .push(txPush), .pop(txPop), .wrByte(txWrByte), .rdByte(txHead),
        .stat(txStat)
    );

    spiFifo rxFifo (
        .PCLK, .PRESETn, .push(rxPush), .pop(rxPop), .wrByte(rxWrByte), .rdByte(rxHead),
        .stat(rxStat)
    );

    spiEngine i_spiEngine (
        .PCLK, .PRESETn, .ctrl, .txStat, .rxStat, .txByte(txHead), .txPop, .rxPush,
        .rxByte(rxWrByte), .SPICLK, .SPIOut, .SPIIn, .SPICS
    );

endmodule

// File: hw/spiEngine.sv
////////////////////
// SPI transfer engine
// Mode 0 frames, MSB first, one chip select per frame
// Clock divider, frame FSM and shift registers
////////////////////
`timescale 1ns/1ns
`include "spi_config.svh"

module spiEngine (
    input  logic                    PCLK,
    input  logic                    PRESETn,
    input  spiRegPkg::spiCtrlT      ctrl,
    input  spiLinkPkg::spiFifoStatT txStat,
    input  spiLinkPkg::spiFifoStatT rxStat,
    input  spiLinkPkg::spiByteT     txByte,
    output logic                    txPop,
    output logic                    rxPush,
    output spiLinkPkg::spiByteT     rxByte,
    output logic                    SPICLK,
    output logic                    SPIOut,
    input  logic                    SPIIn,
    output logic [3:0]              SPICS
);
    import spiRegPkg::*;
    import spiLinkPkg::*;

    localparam int FrameBits = `SPI_FRAME_BITS;
    localparam int BitW      = $clog2(FrameBits);

    typedef enum logic [1:0] {Idle, Active, Release} engStateT;

    engStateT                 state;
    spiCtrlT                  snap;       // Control copy used by the frame
    logic [`SPI_DIV_BITS-1:0] divCnt;
    logic                     tick;       // Half-period boundary
    logic                     start;
    logic                     riseTick;
    logic                     fallTick;
    logic                     lastBit;
    logic [BitW-1:0]          bitCnt;     // Falling edges done in this frame
    spiByteT                  txShift;
    spiByteT                  rxShift;

    // Hold back while the receive FIFO is full, nothing is ever dropped
    assign start    = (state == Idle) & ~txStat.empty & ~rxStat.full;
    assign tick     = (divCnt == snap.sckDiv);
    assign riseTick = (state == Active) & tick & ~SPICLK;
    assign fallTick = (state == Active) & tick & SPICLK;
    assign lastBit  = (bitCnt == BitW'(FrameBits - 1));

    // Register writes only reach a frame between frames
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            snap <= ctrlReset;
        end else if (state == Idle && !start) begin
            snap <= ctrl;
        end
    end

    ////////////////////
    // Divider

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            divCnt <= '0;
        end else if (state == Idle || tick) begin
            divCnt <= '0;                      // Restart each half period
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    ////////////////////
    // Frame FSM

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state  <= Idle;
            SPICLK <= 1'b0;                    // Mode 0 idles low
            bitCnt <= '0;
        end else begin
            case (state)
                Idle: begin
                    bitCnt <= '0;
                    if (start) state <= Active;
                end
                Active: begin
                    if (tick) SPICLK <= ~SPICLK;
                    if (fallTick) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (lastBit) state <= Release;   // CS off for one half period
                    end
                end
                Release: begin
                    if (tick) state <= Idle;
                end
                default: state <= Idle;
            endcase
        end
    end

    // Load on start, next bit out on each falling edge
    always_ff @(posedge PCLK) begin
        if (start) begin
            txShift <= txByte;
        end else if (fallTick && !lastBit) begin
            txShift <= {txShift[FrameBits-2:0], 1'b0};
        end
    end

    // Sample on rising edge
    always_ff @(posedge PCLK) begin
        if (riseTick) rxShift <= {rxShift[FrameBits-2:0], SPIIn};
    end

    assign txPop  = start;
    assign rxPush = fallTick & lastBit;        // Byte is complete after the last rise
    assign rxByte = rxShift;
    assign SPIOut = (state == Active) & txShift[FrameBits-1];

    // Selected chip select flips from its idle level during the frame
    assign SPICS = snap.csDef ^ ({4{state == Active}} & (4'b0001 << snap.csId));

endmodule

// File: hw/spiFifo.sv
////////////////////
// SPI byte FIFO
// Circular buffer with occupancy level, full and empty flags
////////////////////
`timescale 1ns/1ns
`include "spi_config.svh"

module spiFifo #(
    parameter int ABITS = `SPI_FIFO_ABITS
) (
    input  logic                    PCLK,
    input  logic                    PRESETn,
    input  logic                    push,
    input  logic                    pop,
    input  spiLinkPkg::spiByteT     wrByte,
    output spiLinkPkg::spiByteT     rdByte,
    output spiLinkPkg::spiFifoStatT stat
);
    import spiLinkPkg::*;

    localparam int Depth  = 1 << ABITS;
    localparam int LevelW = `SPI_FIFO_ABITS + 1;

    spiByteT          mem [Depth];
    logic [ABITS-1:0] wrPtr;
    logic [ABITS-1:0] rdPtr;    // Head entry
    logic [ABITS:0]   count;
    logic             full;
    logic             empty;
    logic             pushOk;
    logic             popOk;

    assign full   = (count == (ABITS + 1)'(Depth));
    assign empty  = (count == '0);
    assign pushOk = push & ~full;     // Push on full is ignored
    assign popOk  = pop & ~empty;     // So is pop on empty

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushOk) wrPtr <= wrPtr + 1'b1;   // Pointers wrap at depth
            if (popOk) rdPtr <= rdPtr + 1'b1;
            case ({pushOk, popOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                       // Both or neither, level holds
            endcase
        end
    end

    always_ff @(posedge PCLK) begin
        if (pushOk) mem[wrPtr] <= wrByte;
    end

    assign rdByte     = mem[rdPtr];    // Head is visible without a pop
    assign stat.full  = full;
    assign stat.empty = empty;
    assign stat.level = LevelW'(count);

endmodule

// File: hw/spiRegs.sv
////////////////////
// SPI register block
// APB decode, control registers, readback, FIFO strobes
// and watermark interrupt pending bits
////////////////////
`timescale 1ns/1ns
`include "spi_config.svh"

module spiRegs (
    input  logic                    PCLK,
    input  logic                    PRESETn,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [7:0]              PADDR,
    input  spiRegPkg::spiDataWordT  PWDATA,
    output spiRegPkg::spiDataWordT  PRDATA,
    output logic                    PREADY,
    output spiRegPkg::spiCtrlT      ctrl,
    output logic                    txPush,
    output spiLinkPkg::spiByteT     txByte,
    input  spiLinkPkg::spiFifoStatT txStat,
    input  spiLinkPkg::spiFifoStatT rxStat,
    output logic                    rxPop,
    input  spiLinkPkg::spiByteT     rxByte,
    output logic                    SPIIntr
);
    import spiRegPkg::*;

    logic       access;    // APB access phase
    logic       wrEn;
    logic       rdEn;
    logic [7:0] entry;     // Word-aligned offset
    spiIrqT     irqNext;
    spiIrqT     irqPend;

    assign access = PSEL & PENABLE;
    assign wrEn   = access & PWRITE;
    assign rdEn   = access & ~PWRITE;
    assign entry  = {PADDR[7:2], 2'b00};
    assign PREADY = 1'b1;                  // No wait states

    ////////////////////
    // FIFO strobes

    assign txPush = wrEn & (entry == `SPI_OFS_TXDATA) & ~txStat.full;   // Dropped when full
    assign txByte = PWDATA.data.value;
    assign rxPop  = rdEn & (entry == `SPI_OFS_RXDATA) & ~rxStat.empty;

    ////////////////////
    // Control registers

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            ctrl <= ctrlReset;
        end else if (wrEn) begin
            case (entry)
                `SPI_OFS_SCKDIV: ctrl.sckDiv    <= PWDATA.raw[`SPI_DIV_BITS-1:0];
                `SPI_OFS_CSID:   ctrl.csId      <= PWDATA.raw[1:0];
                `SPI_OFS_CSDEF:  ctrl.csDef     <= PWDATA.raw[3:0];
                `SPI_OFS_TXMARK: ctrl.txMark    <= PWDATA.raw[`SPI_FIFO_ABITS-1:0];
                `SPI_OFS_RXMARK: ctrl.rxMark    <= PWDATA.raw[`SPI_FIFO_ABITS-1:0];
                `SPI_OFS_IE:     ctrl.intEnable <= PWDATA.raw[1:0];
                default: ;                     // IP and data registers are not fields
            endcase
        end
    end

    // Readback mux
    always_comb begin
        PRDATA = '0;
        if (rdEn) begin
            case (entry)
                `SPI_OFS_SCKDIV: PRDATA.raw = 32'(ctrl.sckDiv);
                `SPI_OFS_CSID:   PRDATA.raw = 32'(ctrl.csId);
                `SPI_OFS_CSDEF:  PRDATA.raw = 32'(ctrl.csDef);
                `SPI_OFS_TXMARK: PRDATA.raw = 32'(ctrl.txMark);
                `SPI_OFS_RXMARK: PRDATA.raw = 32'(ctrl.rxMark);
                `SPI_OFS_IE:     PRDATA.raw = {30'b0, ctrl.intEnable};
                `SPI_OFS_IP:     PRDATA.raw = {30'b0, irqPend};
                `SPI_OFS_TXDATA: PRDATA.data.flag = txStat.full;
                `SPI_OFS_RXDATA: begin
                    PRDATA.data.flag  = rxStat.empty;
                    PRDATA.data.value = rxStat.empty ? '0 : rxByte;   // Head of receive FIFO
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // Interrupts

    // Level compares against the watermarks
    assign irqNext.txLow  = (txStat.level < {1'b0, ctrl.txMark});
    assign irqNext.rxHigh = (rxStat.level > {1'b0, ctrl.rxMark});

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            irqPend <= '0;
            SPIIntr <= 1'b0;
        end else begin
            irqPend <= irqNext;
            SPIIntr <= |(irqNext & ctrl.intEnable);   // Same cycle as the pending bits
        end
    end

endmodule

// File: hw/spiLinkPkg.sv
////////////////////
// SPI link package
// Types passed between the FIFOs, registers and engine
////////////////////
`include "spi_config.svh"

package spiLinkPkg;

    // One serial frame
    typedef logic [`SPI_FRAME_BITS-1:0] spiByteT;

    // FIFO status as seen by both sides
    typedef struct packed {
        logic                     full;
        logic                     empty;
        logic [`SPI_FIFO_ABITS:0] level;   // Entries held, 0 to depth
    } spiFifoStatT;

endpackage

// File: hw/spiRegPkg.sv
////////////////////
// SPI register package
// Control fields, APB data word views and interrupt bits
////////////////////
`include "spi_config.svh"

package spiRegPkg;

    // Watermark interrupts, txLow sits in bit 0
    typedef struct packed {
        logic rxHigh;  // Receive level above rxMark
        logic txLow;   // Transmit level below txMark
    } spiIrqT;

    typedef struct packed {
        logic [`SPI_DIV_BITS-1:0]   sckDiv;    // Half period is sckDiv+1 PCLK cycles
        logic [1:0]                 csId;      // Which chip select drives the frame
        logic [3:0]                 csDef;     // Idle level of each chip select
        logic [`SPI_FIFO_ABITS-1:0] txMark;
        logic [`SPI_FIFO_ABITS-1:0] rxMark;
        spiIrqT                     intEnable;
    } spiCtrlT;

    // TXDATA and RXDATA use the data view, the rest of the map the raw one
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [32-`SPI_FRAME_BITS-2:0] rsvd;
            logic                          flag;   // Full on TXDATA, empty on RXDATA
            logic [`SPI_FRAME_BITS-1:0]    value;
        } data;
    } spiDataWordT;

    localparam spiCtrlT ctrlReset = '{
        sckDiv: `SPI_DIV_BITS'(3), csId: 2'b00, csDef: 4'b1111, txMark: '0, rxMark: '0,
        intEnable: '{rxHigh: 1'b0, txLow: 1'b0}
    };

endpackage

// File: hw/spi_config.svh
////////////////////
// SPI master configuration
// FIFO depth, frame size, divider width and APB register map
////////////////////
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

`define SPI_FIFO_ABITS 3     // 8 entries per FIFO
`define SPI_FRAME_BITS 8     // One byte per frame
`define SPI_DIV_BITS   12    // Serial clock divider width

// Register byte offsets
`define SPI_OFS_SCKDIV 8'h00
`define SPI_OFS_CSID   8'h10
`define SPI_OFS_CSDEF  8'h14
`define SPI_OFS_TXDATA 8'h48
`define SPI_OFS_RXDATA 8'h4C
`define SPI_OFS_TXMARK 8'h50
`define SPI_OFS_RXMARK 8'h54
`define SPI_OFS_IE     8'h70
`define SPI_OFS_IP     8'h74

`endif
